/* Bender.yml */
package:
  name: cpu_cache

sources:
  - design/cpuPkg.sv
  - design/fetchUnit.sv
  - design/decodeStage.sv
  - design/regFile.sv
  - design/executeStage.sv
  - design/dataCache.sv
  - design/memStage.sv
  - design/backingStore.sv
  - design/cpuTop.sv
  - target: test
    files:
      - test/cpuChecker.sv
      - test/cpuTb.sv

/* design/backingStore.sv */
// 256-byte store, one byte per cycle; a request must stay high until done or the beat count slips
module backingStore (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::memReqT memReq,
    output cpuPkg::memRspT memRsp
);
    import cpuPkg::*;

    dataT        mem [256];
    logic [1:0]  beat;
    logic [23:0] rdBuf;     // bytes 0..2 of a read burst
    logic        busy;
    memAddrT     beatAddr;

    assign busy     = memReq.rdReq || memReq.wrReq;
    assign beatAddr = {memReq.lineAddr[7:2], beat};

    // last byte goes straight through on the done beat
    assign memRsp = '{done: busy && beat == 2'd3, rdLine: {rdBuf, mem[beatAddr]}};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            beat <= '0;
            for (int a = 0; a < 256; a++) begin
                mem[a] <= memAddrT'(a) ^ storeSeed;
            end
        end else if (busy) begin
            beat <= beat + 2'd1;    // wraps to 0 after done
            if (memReq.wrReq) begin
                mem[beatAddr] <= memReq.wrLine[{~beat, 3'b000} +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memReq.rdReq) rdBuf <= {rdBuf[15:0], mem[beatAddr]};
    end

    // done closes a burst the cache has held for three cycles before
    doneInBurst: assert property (@(posedge clk) disable iff (!arstN)
        memRsp.done |-> $past(busy, 1) && $past(busy, 2) && $past(busy, 3));

endmodule

/* design/cpuPkg.sv */
// shared types and encodings; addresses are 8 bits, so storage and the cache map exactly 256 bytes
package cpuPkg;

    typedef logic [31:0] instrT;
    typedef logic [7:0]  dataT;
    typedef logic [4:0]  regAddrT;
    typedef logic [15:0] immT;
    typedef logic [4:0]  shamtT;
    typedef logic [7:0]  memAddrT;
    typedef logic [31:0] lineT;     // byte 0 sits in bits 31..24

    // byte address split: index 7..6, tag 5..2, offset 1..0
    typedef logic [3:0] tagT;
    typedef logic [1:0] indexT;
    typedef logic [1:0] offsetT;

    typedef enum logic [3:0] {
        aluNone = 4'd0,
        aluAdd  = 4'd1,
        aluSub  = 4'd2,
        aluAnd  = 4'd3,
        aluOr   = 4'd4,
        aluXor  = 4'd5,
        aluSll  = 4'd6,
        aluSrl  = 4'd7,
        aluSlt  = 4'd8
    } aluOpT;

    localparam logic [5:0] opRtype    = 6'd0;   // operation in funct[3:0]
    localparam logic [5:0] opImmFirst = 6'd1;   // immediate forms carry the operation in opcode[3:0]
    localparam logic [5:0] opImmLast  = 6'd8;
    localparam logic [5:0] opLoad     = 6'd9;
    localparam logic [5:0] opStore    = 6'd10;

    localparam dataT storeSeed = 8'h5a;         // storage byte a comes out of reset as a ^ seed

    typedef struct packed {
        aluOpT   aluOp;
        regAddrT rsAddr;
        regAddrT rtAddr;
        regAddrT destAddr;
        immT     imm;
        shamtT   shamt;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    aluSrc;
        logic    memToReg;
    } idExT;

    typedef struct packed {
        dataT    aluResult;
        dataT    storeData;
        regAddrT destAddr;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
    } exMemT;

    typedef struct packed {
        logic    wbValid;
        regAddrT wbAddr;
        dataT    wbData;
    } wbT;

    // request is a level held until done
    typedef struct packed {
        logic    rdReq;
        logic    wrReq;
        memAddrT lineAddr;  // low two bits zero
        lineT    wrLine;
    } memReqT;

    typedef struct packed {
        logic done;         // one-cycle pulse on the fourth beat
        lineT rdLine;
    } memRspT;

endpackage

/* design/cpuTop.sv */
// program memory sits outside; instr must follow pc combinationally, and there is no forwarding
module cpuTop #(
    parameter int pcWidth = 6
) (
    input  logic               clk,
    input  logic               arstN,
    output logic [pcWidth-1:0] pc,
    input  cpuPkg::instrT      instr,
    output cpuPkg::wbT         wb,
    output logic               stall
);
    import cpuPkg::*;

    instrT  fetched;
    idExT   idEx;
    dataT   rsData;
    dataT   rtData;
    exMemT  exMem;
    memReqT memReq;
    memRspT memRsp;

    fetchUnit #(.pcWidth(pcWidth)) fetchUnit_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .instr(instr), .pc(pc), .fetched(fetched)
    );

    decodeStage decodeStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .fetched(fetched), .idEx(idEx)
    );

    regFile regFile_inst (
        .clk(clk), .arstN(arstN), .rsAddr(idEx.rsAddr), .rtAddr(idEx.rtAddr),
        .wb(wb), .rsData(rsData), .rtData(rtData)
    );

    executeStage executeStage_inst (
        .clk(clk), .arstN(arstN), .stall(stall), .idEx(idEx),
        .rsData(rsData), .rtData(rtData), .exMem(exMem)
    );

    memStage memStage_inst (
        .clk(clk), .arstN(arstN), .exMem(exMem), .memRsp(memRsp),
        .memReq(memReq), .wb(wb), .stall(stall)
    );

    backingStore backingStore_inst (
        .clk(clk), .arstN(arstN), .memReq(memReq), .memRsp(memRsp)
    );

endmodule

/* design/dataCache.sv */
// 4 direct-mapped 32-bit lines, write-back and write-allocate; one outstanding miss at a time
module dataCache (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::exMemT  exMem,
    input  cpuPkg::memRspT memRsp,
    output cpuPkg::memReqT memReq,
    output cpuPkg::dataT   loadData,
    output logic           stall
);
    import cpuPkg::*;

    typedef enum logic [1:0] {lookup, writeBack, refill} cacheStateT;

    cacheStateT state;
    cacheStateT nextState;
    lineT       dataArr [4];
    tagT        tagArr [4];
    logic [3:0] validArr;
    logic [3:0] dirtyArr;
    indexT      index;
    tagT        tag;
    offsetT     offset;
    logic       memOp;
    logic       hit;
    logic       fillDone;
    logic       storeHit;
    logic       rdReq;
    logic       wrReq;

    assign index  = exMem.aluResult[7:6];
    assign tag    = exMem.aluResult[5:2];
    assign offset = exMem.aluResult[1:0];
    assign memOp  = exMem.memRead || exMem.memWrite;
    assign hit    = validArr[index] && (tagArr[index] == tag);

    assign stall    = memOp && !(hit && state == lookup);
    assign fillDone = (state == refill) && memRsp.done;
    assign storeHit = exMem.memWrite && hit && (state == lookup);
    assign loadData = dataArr[index][{~offset, 3'b000} +: 8];    // byte 0 is the top byte

    // the miss cycle itself already raises the request, so no beat is lost
    always_comb begin
        nextState = state;
        rdReq     = 1'b0;
        wrReq     = 1'b0;
        case (state)
            lookup: if (memOp && !hit) begin
                if (validArr[index] && dirtyArr[index]) begin
                    wrReq     = 1'b1;
                    nextState = writeBack;
                end else begin
                    rdReq     = 1'b1;
                    nextState = refill;
                end
            end
            writeBack: begin
                wrReq = 1'b1;
                if (memRsp.done) nextState = refill;
            end
            refill: begin
                rdReq = 1'b1;
                if (memRsp.done) nextState = lookup;
            end
            default: nextState = lookup;
        endcase
    end

    // victim address comes from the stored tag, the fill address from the request
    assign memReq = '{rdReq:    rdReq,
                      wrReq:    wrReq,
                      lineAddr: wrReq ? {index, tagArr[index], 2'b00} : {index, tag, 2'b00},
                      wrLine:   dataArr[index]};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= lookup;
            validArr <= '0;
            dirtyArr <= '0;
        end else begin
            state <= nextState;
            if (fillDone) begin
                validArr[index] <= 1'b1;
                dirtyArr[index] <= 1'b0;    // fresh copy of storage
            end else if (storeHit) begin
                dirtyArr[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fillDone) begin
            dataArr[index] <= memRsp.rdLine;
            tagArr[index]  <= tag;
        end else if (storeHit) begin
            dataArr[index][{~offset, 3'b000} +: 8] <= exMem.storeData;
        end
    end

    // the stalled access must still sit unchanged in EX/MEM a cycle later
    stallHoldsOp: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> memOp && $stable(exMem.aluResult));

    reqExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(memReq.rdReq && memReq.wrReq));

endmodule

/* design/decodeStage.sv */
// no hazard detection here; software must keep three instructions between a write and its use
module decodeStage (
    input  logic          clk,
    input  logic          arstN,
    input  logic          stall,
    input  cpuPkg::instrT fetched,
    output cpuPkg::idExT  idEx
);
    import cpuPkg::*;

    logic [5:0] opcode;
    idExT       dec;

    assign opcode = fetched[31:26];

    always_comb begin
        dec          = '0;
        dec.rsAddr   = fetched[25:21];
        dec.rtAddr   = fetched[20:16];    // also the store data register
        dec.destAddr = fetched[20:16];
        dec.imm      = fetched[15:0];
        dec.shamt    = fetched[10:6];
        if (opcode == opRtype) begin
            dec.aluOp    = aluOpT'(fetched[3:0]);
            dec.destAddr = fetched[15:11];    // rd field
            dec.regWrite = 1'b1;
        end else if (opcode >= opImmFirst && opcode <= opImmLast) begin
            dec.aluOp    = aluOpT'(opcode[3:0]);
            dec.aluSrc   = 1'b1;
            dec.regWrite = 1'b1;
        end else if (opcode == opLoad) begin
            dec.aluOp    = aluAdd;    // base plus offset
            dec.aluSrc   = 1'b1;
            dec.regWrite = 1'b1;
            dec.memRead  = 1'b1;
            dec.memToReg = 1'b1;
        end else if (opcode == opStore) begin
            dec.aluOp    = aluAdd;
            dec.aluSrc   = 1'b1;
            dec.memWrite = 1'b1;
        end
        // writes to r0 are dropped here so later stages never see them
        dec.regWrite = dec.regWrite && (dec.destAddr != '0);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= dec;
        end
    end

endmodule

/* design/executeStage.sv */
// 8-bit ALU; only set-less-than looks at the full 16-bit second operand, compared unsigned
module executeStage (
    input  logic          clk,
    input  logic          arstN,
    input  logic          stall,
    input  cpuPkg::idExT  idEx,
    input  cpuPkg::dataT  rsData,
    input  cpuPkg::dataT  rtData,
    output cpuPkg::exMemT exMem
);
    import cpuPkg::*;

    immT  operand2;
    dataT aluResult;

    assign operand2 = idEx.aluSrc ? idEx.imm : {8'h00, rtData};

    always_comb begin
        case (idEx.aluOp)
            aluAdd:  aluResult = rsData + operand2[7:0];
            aluSub:  aluResult = rsData - operand2[7:0];
            aluAnd:  aluResult = rsData & operand2[7:0];
            aluOr:   aluResult = rsData | operand2[7:0];
            aluXor:  aluResult = rsData ^ operand2[7:0];
            aluSll:  aluResult = rsData << idEx.shamt;
            aluSrl:  aluResult = rsData >> idEx.shamt;
            aluSlt:  aluResult = ({8'h00, rsData} < operand2) ? 8'd1 : 8'd0;
            default: aluResult = '0;    // unused codes give zero
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMem <= '0;
        end else if (!stall) begin
            exMem <= '{aluResult: aluResult,
                       storeData: rtData,
                       destAddr:  idEx.destAddr,
                       regWrite:  idEx.regWrite,
                       memRead:   idEx.memRead,
                       memWrite:  idEx.memWrite,
                       memToReg:  idEx.memToReg};
        end
    end

endmodule

/* design/fetchUnit.sv */
// program counter wraps at 2**pcWidth; the program memory must answer instr in the same cycle
module fetchUnit #(
    parameter int pcWidth = 6
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 stall,
    input  cpuPkg::instrT        instr,
    output logic [pcWidth-1:0]   pc,
    output cpuPkg::instrT        fetched
);

    // pc and IF/ID both freeze while the cache is busy
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            fetched <= '0;    // all-zero word decodes as a no-op
        end else if (!stall) begin
            pc      <= pc + 1'b1;
            fetched <= instr;
        end
    end

endmodule

/* design/memStage.sv */
// wbValid is masked while stalled, so each instruction reaches the register file exactly once
module memStage (
    input  logic           clk,
    input  logic           arstN,
    input  cpuPkg::exMemT  exMem,
    input  cpuPkg::memRspT memRsp,
    output cpuPkg::memReqT memReq,
    output cpuPkg::wbT     wb,
    output logic           stall
);
    import cpuPkg::*;

    dataT loadData;
    wbT   memWb;    // MEM/WB register, data already selected

    dataCache dataCache_inst (
        .clk      (clk),
        .arstN    (arstN),
        .exMem    (exMem),
        .memRsp   (memRsp),
        .memReq   (memReq),
        .loadData (loadData),
        .stall    (stall)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memWb <= '0;
        end else if (!stall) begin
            memWb <= '{wbValid: exMem.regWrite,
                       wbAddr:  exMem.destAddr,
                       wbData:  exMem.memToReg ? loadData : exMem.aluResult};
        end
    end

    assign wb = '{wbValid: memWb.wbValid && !stall, wbAddr: memWb.wbAddr, wbData: memWb.wbData};

endmodule

/* design/regFile.sv */
// reads are combinational from the ID/EX addresses; a write is visible from the next cycle only
module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::regAddrT rsAddr,
    input  cpuPkg::regAddrT rtAddr,
    input  cpuPkg::wbT      wb,
    output cpuPkg::dataT    rsData,
    output cpuPkg::dataT    rtData
);
    import cpuPkg::*;

    dataT regs [32];

    assign rsData = regs[rsAddr];
    assign rtData = regs[rtAddr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (wb.wbValid && wb.wbAddr != '0) begin   // r0 stays zero
            regs[wb.wbAddr] <= wb.wbData;
        end
    end

    // decode already strips r0 destinations
    wbNotR0: assert property (@(posedge clk) disable iff (!arstN)
        wb.wbValid |-> wb.wbAddr != '0);

endmodule

/* tb.f */
design/cpuPkg.sv
design/fetchUnit.sv
design/decodeStage.sv
design/regFile.sv
design/executeStage.sv
design/dataCache.sv
design/memStage.sv
design/backingStore.sv
design/cpuTop.sv
test/cpuChecker.sv
test/cpuTb.sv

/* test/cpuChecker.sv */
// replays the ROM on a model once reset is released; the ROM must be filled before that
module cpuChecker #(
    parameter int pcWidth = 6,
    parameter int endPc   = 60
) (
    input  logic               clk,
    input  logic               arstN,
    input  logic [pcWidth-1:0] pc,
    input  logic               stall,
    input  cpuPkg::wbT         wb,
    input  cpuPkg::instrT      rom [2**pcWidth],
    output int                 errorCount,
    output int                 timeoutCount,
    output int                 checkCount,
    output logic               done
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    localparam int resetLimit = 10;
    localparam int runLimit   = 3000;
    localparam int drainLimit = 200;

    dataT    regs [32];
    dataT    mem [256];
    tagT     lineTag [4];
    logic    lineValid [4];
    logic    lineDirty [4];
    regAddrT expAddr [$];
    dataT    expData [$];
    int      expStall [$];  // stall cycles per miss in program order
    int      expMisses;
    int      victims;       // dirty lines the model writes back
    int      seen;
    int      stallEdges;
    int      stallCycles;
    logic    prevStall;
    int      cycles;

    function automatic dataT aluCompute(logic [3:0] code, dataT a, immT b, shamtT sh);
        case (code)
            4'd1: return a + b[7:0];
            4'd2: return a - b[7:0];
            4'd3: return a & b[7:0];
            4'd4: return a | b[7:0];
            4'd5: return a ^ b[7:0];
            4'd6: return a << sh;
            4'd7: return a >> sh;
            4'd8: return dataT'(a < b);    // 16-bit unsigned compare
            default: return 8'h00;
        endcase
    endfunction

    task automatic cacheAccess(memAddrT addr, logic isStore);
        indexT idx;
        idx = addr[7:6];
        if (!lineValid[idx] || lineTag[idx] != addr[5:2]) begin
            expMisses++;
            if (lineValid[idx] && lineDirty[idx]) begin
                victims++;
                expStall.push_back(8);    // write-back burst then refill burst
            end else begin
                expStall.push_back(4);    // refill burst only
            end
            lineValid[idx] = 1'b1;
            lineTag[idx]   = addr[5:2];
            lineDirty[idx] = 1'b0;
        end
        if (isStore) lineDirty[idx] = 1'b1;
    endtask

    task automatic buildExpected();
        instrT      w;
        logic [5:0] op;
        memAddrT    addr;
        dataT       val;
        regAddrT    dest;
        logic       writes;
        int         i;
        for (i = 0; i < 256; i++) mem[i] = dataT'(i) ^ storeSeed;
        regs      = '{default: '0};
        lineValid = '{default: 1'b0};
        lineDirty = '{default: 1'b0};
        expMisses = 0;
        victims   = 0;
        for (i = 0; i < 2**pcWidth; i++) begin
            w      = rom[i];
            op     = w[31:26];
            addr   = regs[w[25:21]] + w[7:0];
            dest   = w[20:16];
            writes = 1'b1;
            val    = 8'h00;
            if (op == 6'd0) begin
                dest = w[15:11];
                val  = aluCompute(w[3:0], regs[w[25:21]], {8'h00, regs[w[20:16]]}, w[10:6]);
            end else if (op >= 6'd1 && op <= 6'd8) begin
                val = aluCompute(op[3:0], regs[w[25:21]], w[15:0], w[10:6]);
            end else if (op == 6'd9) begin
                cacheAccess(addr, 1'b0);
                val = mem[addr];
            end else begin
                writes = 1'b0;
                if (op == 6'd10) begin
                    cacheAccess(addr, 1'b1);
                    mem[addr] = regs[w[20:16]];
                end
            end
            if (writes && dest != 5'd0) begin    // r0 is never written
                regs[dest] = val;
                expAddr.push_back(dest);
                expData.push_back(val);
            end
        end
        $display("model: %0d write-backs, %0d misses, %0d dirty evictions",
                 expAddr.size(), expMisses, victims);
    endtask

    task automatic checkResetState();
        checkCount++;
        if (pc !== '0 || stall !== 1'b0 || wb.wbValid !== 1'b0) begin
            errorCount++;
            $display("error %0d ns: not idle around reset, pc %0d stall %b wbValid %b",
                     $time, pc, stall, wb.wbValid);
        end
    endtask

    task automatic sampleCycle();
        if (stall) begin
            if (!prevStall) stallEdges++;
            stallCycles++;
        end else if (prevStall) begin
            checkCount++;
            if (stallEdges > expStall.size()) begin
                errorCount++;
                $display("error %0d ns: stall %0d has no matching miss in the model",
                         $time, stallEdges);
            end else if (stallCycles != expStall[stallEdges-1]) begin
                errorCount++;
                $display("error %0d ns: miss %0d stalled %0d cycles, expected %0d",
                         $time, stallEdges, stallCycles, expStall[stallEdges-1]);
            end
            stallCycles = 0;
        end
        prevStall = stall;
        if (wb.wbValid) begin
            checkCount++;
            if (seen >= expAddr.size()) begin
                errorCount++;
                $display("error %0d ns: unexpected write-back r%0d = %02h",
                         $time, wb.wbAddr, wb.wbData);
            end else if (wb.wbAddr !== expAddr[seen] || wb.wbData !== expData[seen]) begin
                errorCount++;
                $display("error %0d ns: write-back %0d expected r%0d = %02h, got r%0d = %02h",
                         $time, seen, expAddr[seen], expData[seen], wb.wbAddr, wb.wbData);
            end
            seen++;
        end
    endtask

    initial begin
        done         = 1'b0;
        errorCount   = 0;
        timeoutCount = 0;
        checkCount   = 0;
        seen         = 0;
        stallEdges   = 0;
        stallCycles  = 0;
        prevStall    = 1'b0;
        cycles       = 0;
        // last pass of this loop is the first cycle after reset
        do begin
            @(negedge clk);
            checkResetState();
            cycles++;
        end while (!arstN && cycles < resetLimit);
        if (!arstN) begin
            timeoutCount++;
            $display("timeout: reset still asserted after %0d cycles", resetLimit);
        end
        buildExpected();
        cycles = 0;
        while (seen < expAddr.size() && cycles < runLimit) begin
            @(negedge clk);
            sampleCycle();
            cycles++;
        end
        if (seen < expAddr.size()) begin
            timeoutCount++;
            $display("timeout: only %0d of %0d write-backs arrived within %0d cycles",
                     seen, expAddr.size(), runLimit);
        end
        cycles = 0;
        while (pc < endPc && cycles < drainLimit) begin    // trailing stores may still miss
            @(negedge clk);
            sampleCycle();
            cycles++;
        end
        if (pc < endPc) begin
            timeoutCount++;
            $display("timeout: pc did not reach %0d within %0d cycles", endPc, drainLimit);
        end
        checkCount++;
        if (stallEdges != expMisses) begin
            errorCount++;
            $display("error %0d ns: saw %0d stalls, model expects %0d cache misses",
                     $time, stallEdges, expMisses);
        end
        done = 1'b1;
    end

endmodule

/* test/cpuTb.sv */
// 56 random instructions then no-ops; sources never name the last three destinations
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuPkg::*;

    localparam int    pcWidth       = 6;
    localparam int    romDepth      = 2 ** pcWidth;
    localparam int    randCount     = 56;
    localparam int    watchdogLimit = 4000;          // clock cycles for the whole run
    localparam instrT nopWord       = 32'hfc00_0000; // opcode 63 does nothing

    logic               clk;
    logic               arstN;
    logic [pcWidth-1:0] pc;
    instrT              instr;
    wbT                 wb;
    logic               stall;
    instrT              rom [romDepth];
    logic [31:0]        lcgState;
    regAddrT            recentDest [3];    // 0 marks a slot with no register write
    int                 errorCount;
    int                 timeoutCount;
    int                 checkCount;
    logic               checkDone;
    int                 cycles;

    assign instr = rom[pc];    // program memory answers in the same cycle

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic hitsRecentDest(regAddrT r);
        return r != 5'd0 && (r == recentDest[0] || r == recentDest[1] || r == recentDest[2]);
    endfunction

    function automatic regAddrT drawSource();
        regAddrT r;
        r = regAddrT'(nextRand() >> 27);
        while (hitsRecentDest(r)) r = regAddrT'(nextRand() >> 27);
        return r;
    endfunction

    // any index, tag 0 or 1, any offset: lots of conflicts and address reuse
    function automatic immT memOffset();
        logic [31:0] n;
        n = nextRand();
        return {8'h00, n[31:30], 3'b000, n[29:27]};
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [31:0] n;
        int          kind;
        int          i;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        regAddrT     written;
        recentDest = '{default: '0};
        for (i = 0; i < romDepth; i++) rom[i] = nopWord;
        for (i = 0; i < randCount; i++) begin
            r    = nextRand();
            n    = nextRand();
            kind = int'(r[31:16] % 10);
            rs   = drawSource();
            rt   = drawSource();
            rd   = (n[31:29] == 3'd0) ? 5'd0 : n[28:24];    // r0 now and then
            case (kind)
                0, 1, 2: begin    // R-type, funct code 0 gives zero
                    rom[i]  = {6'd0, rs, rt, rd, 2'b00, n[21:19], 2'b00, 4'(n[15:8] % 9)};
                    written = rd;
                end
                3, 4, 5: begin
                    rom[i]  = {6'(1 + n[15:8] % 8), rs, rd,
                               n[7] ? n[23:8] : {8'h00, n[23:16]}};
                    written = rd;
                end
                6, 7: begin    // loads and stores use r0 as base
                    rom[i]  = {6'd9, 5'd0, rd, memOffset()};
                    written = rd;
                end
                default: begin
                    rom[i]  = {6'd10, 5'd0, rt, memOffset()};
                    written = 5'd0;
                end
            endcase
            recentDest[2] = recentDest[1];
            recentDest[1] = recentDest[0];
            recentDest[0] = written;
        end
    endtask

    cpuTop #(.pcWidth(pcWidth)) cpuTop_inst (
        .clk(clk), .arstN(arstN), .pc(pc), .instr(instr), .wb(wb), .stall(stall)
    );

    // the last random instruction has cleared memory once pc passes randCount + 3
    cpuChecker #(.pcWidth(pcWidth), .endPc(randCount + 4)) cpuChecker_inst (
        .clk(clk), .arstN(arstN), .pc(pc), .stall(stall), .wb(wb), .rom(rom),
        .errorCount(errorCount), .timeoutCount(timeoutCount), .checkCount(checkCount),
        .done(checkDone)
    );

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        lcgState = 32'hf8c7b089;
        buildProgram();
        repeat (2) @(posedge clk);
        #1 arstN = 1'b1;
        cycles = 0;
        while (!checkDone && cycles < watchdogLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!checkDone) $display("timeout: checker still busy after %0d cycles", watchdogLimit);
        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (checkDone && errorCount == 0 && timeoutCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
